//--- Makefile
# Verilator build and run of the usb hid report testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_usb_hid
FILELIST = verilog.f
RUNFLAGS = +verilator+error+limit+1000
PASS_MSG = ** PASS **

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(RUNFLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir

//--- hid_class_detect.sv
// hid class detect
// stores the interface descriptor fields and classifies the device
// as keyboard, mouse or gamepad once the protocol field is written;
// a disconnect drops the type back to none
`timescale 1ns/100ps
`include "usb_hid_settings.svh"

module hid_class_detect (
    input  logic                     usbclk,
    input  logic                     usbrst_n,
    input  usb_hid_pkg::desc_wr_t    desc,
    input  logic                     connected,
    output usb_hid_pkg::dev_type_e   typ
);

    logic [7:0]             field_q [`USB_HID_DESC_FIELDS];  // vid, pid, class, sub, proto
    logic                   proto_wr_q;   // protocol field written last cycle
    logic                   conn_q;
    usb_hid_pkg::dev_type_e typ_next;

    // descriptor field registers
    always_ff @(posedge usbclk) begin
        if (desc.desc_valid && (desc.field < `USB_HID_DESC_FIELDS)) begin
            field_q[desc.field] <= desc.value;
        end
    end

    always_comb begin
        if (field_q[`USB_HID_FIELD_CLASS] != `USB_HID_CLASS_HID) begin
            typ_next = usb_hid_pkg::dev_none;
        end else if (field_q[`USB_HID_FIELD_SUBCLASS] == `USB_HID_SUBCLASS_BOOT) begin
            // boot devices are keyboard or mouse
            typ_next = (field_q[`USB_HID_FIELD_PROTOCOL] == `USB_HID_PROTO_KEYBOARD) ?
                       usb_hid_pkg::dev_keyboard : usb_hid_pkg::dev_mouse;
        end else begin
            typ_next = usb_hid_pkg::dev_gamepad;  // report layout guessed
        end
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            typ        <= usb_hid_pkg::dev_none;
            proto_wr_q <= 1'b0;
            conn_q     <= 1'b0;
        end else begin
            proto_wr_q <= desc.desc_valid && (desc.field == `USB_HID_FIELD_PROTOCOL);
            conn_q     <= connected;

            if (proto_wr_q) begin
                typ <= typ_next;
            end

            // disconnect wins over a classification in the same cycle
            if (conn_q && !connected) begin
                typ <= usb_hid_pkg::dev_none;
            end
        end
    end

endmodule

//--- hid_report_capture.sv
// hid report capture
// indexes the strobed bytes of a report frame, keeps the first eight
// as the raw report and flags the falling edge of the frame
`timescale 1ns/100ps
`include "usb_hid_settings.svh"

module hid_report_capture (
    input  logic                                usbclk,
    input  logic                                usbrst_n,
    input  usb_hid_pkg::link_in_t               link,
    output usb_hid_pkg::byte_evt_t              evt,
    output logic                                frame_end,
    output logic [`USB_HID_REPORT_BYTES*8-1:0]  raw_report
);

    logic [`USB_HID_IDX_W:0]   byte_cnt;  // extra bit holds the count past the last byte
    logic [`USB_HID_IDX_W-1:0] byte_idx;
    logic                      frame_q;
    logic                      take;

    assign byte_idx = byte_cnt[`USB_HID_IDX_W-1:0];

    // only the first eight bytes of a frame count
    assign take = link.frame && link.byte_valid &&
                  (byte_cnt < `USB_HID_REPORT_BYTES);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            byte_cnt   <= '0;
            frame_q    <= 1'b0;
            frame_end  <= 1'b0;
            evt        <= '0;
            raw_report <= '0;
        end else begin
            frame_q   <= link.frame;
            frame_end <= frame_q && !link.frame;  // falling edge of frame
            evt.valid <= take;

            if (take) begin
                evt.idx  <= byte_idx;
                evt.data <= link.data;
                raw_report[{byte_idx, 3'b000} +: 8] <= link.data;
                byte_cnt <= byte_cnt + 1'b1;
            end

            if (!link.frame) begin
                byte_cnt <= '0;  // idle between frames
            end
        end
    end

endmodule

//--- hid_report_decode.sv
// hid report decode
// applies each captured report byte to the keyboard, mouse or gamepad
// view of the state word, selected by the device type, and pulses
// report once per frame when a device is present
`timescale 1ns/100ps
`include "usb_hid_settings.svh"

module hid_report_decode (
    input  logic                     usbclk,
    input  logic                     usbrst_n,
    input  usb_hid_pkg::dev_type_e   typ,
    input  usb_hid_pkg::byte_evt_t   evt,
    input  logic                     frame_end,
    output logic                     report,
    output usb_hid_pkg::hid_state_u  state
);

    logic pad_keep;  // byte 0 of a gamepad record carries no skip mark

    assign pad_keep = (evt.data[1:0] != `USB_HID_PAD_SKIP_MARK);

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            report <= 1'b0;
            state  <= '0;
        end else begin
            report <= frame_end && (typ != usb_hid_pkg::dev_none);

            // mouse motion is relative, so it lasts one report
            if (report && (typ == usb_hid_pkg::dev_mouse)) begin
                state.mouse.dx <= '0;
                state.mouse.dy <= '0;
            end

            if (evt.valid) begin
                case (typ)
                    usb_hid_pkg::dev_keyboard: begin
                        case (evt.idx)
                            3'd0: state.kbd.modifiers <= evt.data;
                            3'd2: state.kbd.key1 <= evt.data;
                            3'd3: state.kbd.key2 <= evt.data;
                            3'd4: state.kbd.key3 <= evt.data;
                            3'd5: state.kbd.key4 <= evt.data;
                            default: ;  // byte 1 reserved, 6 and 7 unused
                        endcase
                    end

                    usb_hid_pkg::dev_mouse: begin
                        case (evt.idx)
                            3'd0: state.mouse.buttons <= evt.data;
                            3'd1: state.mouse.dx <= evt.data;
                            3'd2: state.mouse.dy <= evt.data;
                            default: ;  // wheel and vendor bytes
                        endcase
                    end

                    usb_hid_pkg::dev_gamepad: begin
                        case (evt.idx)
                            3'd0: begin
                                state.pad.valid <= pad_keep;
                                if (pad_keep) begin
                                    state.pad.l <= 1'b0;
                                    state.pad.r <= 1'b0;
                                    state.pad.u <= 1'b0;
                                    state.pad.d <= 1'b0;
                                end
                                // some pads report the x axis in byte 0
                                if (evt.data == 8'h00) begin
                                    state.pad.l <= 1'b1;
                                    state.pad.r <= 1'b0;
                                end
                                if (evt.data == 8'hff) begin
                                    state.pad.l <= 1'b0;
                                    state.pad.r <= 1'b1;
                                end
                            end
                            3'd1: begin
                                if (evt.data == 8'h00) begin
                                    state.pad.u <= 1'b1;
                                    state.pad.d <= 1'b0;
                                end
                                if (evt.data == 8'hff) begin
                                    state.pad.u <= 1'b0;
                                    state.pad.d <= 1'b1;
                                end
                            end
                            3'd3: if (state.pad.valid) begin  // x axis
                                if (evt.data[7:6] == 2'b00) begin
                                    state.pad.l <= 1'b1;
                                    state.pad.r <= 1'b0;
                                end
                                if (evt.data[7:6] == 2'b11) begin
                                    state.pad.l <= 1'b0;
                                    state.pad.r <= 1'b1;
                                end
                            end
                            3'd4: if (state.pad.valid) begin  // y axis
                                if (evt.data[7:6] == 2'b00) begin
                                    state.pad.u <= 1'b1;
                                    state.pad.d <= 1'b0;
                                end
                                if (evt.data[7:6] == 2'b11) begin
                                    state.pad.u <= 1'b0;
                                    state.pad.d <= 1'b1;
                                end
                            end
                            3'd5: if (state.pad.valid) begin
                                state.pad.x <= evt.data[4];
                                state.pad.a <= evt.data[5];
                                state.pad.b <= evt.data[6];
                                state.pad.y <= evt.data[7];
                            end
                            3'd6: if (state.pad.valid) begin
                                state.pad.sel <= evt.data[4];
                                state.pad.sta <= evt.data[5];
                            end
                            default: ;
                        endcase
                    end

                    default: ;  // no device, bytes dropped
                endcase
            end
        end
    end

endmodule

//--- tb_usb_hid.sv
// testbench for the usb hid report block
// classifies keyboard, mouse and gamepad devices, sends random report
// frames and compares the decoded state with a reference model
`timescale 1ns/100ps
`include "usb_hid_settings.svh"

module tb_usb_hid;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int KBD_FRAMES    = 20;
    localparam int MOUSE_FRAMES  = 20;
    localparam int PAD_FRAMES    = 30;
    localparam int N_FRAMES      = KBD_FRAMES + MOUSE_FRAMES + PAD_FRAMES + 4;
    localparam int FRAME_CYCLES  = 40;   // longest frame plus its gap
    localparam int MARGIN_CYCLES = 400;  // reset and descriptor writes

    typedef struct packed {
        usb_hid_pkg::dev_type_e              typ;
        usb_hid_pkg::hid_state_u             state;
        logic [`USB_HID_REPORT_BYTES*8-1:0]  raw;
    } expect_t;

    logic                                usbclk;
    logic                                usbrst_n;
    usb_hid_pkg::link_in_t               link;
    usb_hid_pkg::desc_wr_t               desc;
    usb_hid_pkg::dev_type_e              typ;
    logic                                report;
    usb_hid_pkg::hid_state_u             state;
    logic [`USB_HID_REPORT_BYTES*8-1:0]  raw_report;

    logic [31:0]             lcg_state;
    expect_t                 exp_q[$];
    usb_hid_pkg::dev_type_e  cur_typ;     // type the model expects
    usb_hid_pkg::hid_state_u model;
    logic [63:0]             model_raw;
    logic [7:0]              frame_buf [16];
    int                      value_errs;
    int                      other_errs;
    int                      reports_seen;

    usb_hid_report dut_i (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .link       (link),
        .desc       (desc),
        .typ        (typ),
        .report     (report),
        .state      (state),
        .raw_report (raw_report)
    );

    initial usbclk = 1'b0;
    always #(CLK_PERIOD / 2) usbclk = ~usbclk;

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];  // upper bits have the longer period
    endfunction

    // expected state after one frame, from the report layouts
    function automatic usb_hid_pkg::hid_state_u ref_state(
        input usb_hid_pkg::dev_type_e  dtyp,
        input logic [7:0]              bytes [16],
        input int                      n,
        input usb_hid_pkg::hid_state_u prev
    );
        usb_hid_pkg::hid_state_u s;
        logic [7:0]              b;
        s = prev;
        for (int i = 0; i < n && i < `USB_HID_REPORT_BYTES; i++) begin
            b = bytes[i];
            if (dtyp == usb_hid_pkg::dev_keyboard) begin
                case (i)
                    0: s.kbd.modifiers = b;
                    2: s.kbd.key1 = b;
                    3: s.kbd.key2 = b;
                    4: s.kbd.key3 = b;
                    5: s.kbd.key4 = b;
                    default: ;
                endcase
            end else if (dtyp == usb_hid_pkg::dev_mouse) begin
                case (i)
                    0: s.mouse.buttons = b;
                    1: s.mouse.dx = b;
                    2: s.mouse.dy = b;
                    default: ;
                endcase
            end else if (dtyp == usb_hid_pkg::dev_gamepad) begin
                case (i)
                    0: begin
                        s.pad.valid = (b[1:0] != `USB_HID_PAD_SKIP_MARK);
                        if (s.pad.valid) {s.pad.l, s.pad.r, s.pad.u, s.pad.d} = 4'b0000;
                        if (b == 8'h00) {s.pad.l, s.pad.r} = 2'b10;
                        if (b == 8'hff) {s.pad.l, s.pad.r} = 2'b01;
                    end
                    1: begin
                        if (b == 8'h00) {s.pad.u, s.pad.d} = 2'b10;
                        if (b == 8'hff) {s.pad.u, s.pad.d} = 2'b01;
                    end
                    3: begin
                        if (s.pad.valid && b[7:6] == 2'b00) {s.pad.l, s.pad.r} = 2'b10;
                        if (s.pad.valid && b[7:6] == 2'b11) {s.pad.l, s.pad.r} = 2'b01;
                    end
                    4: begin
                        if (s.pad.valid && b[7:6] == 2'b00) {s.pad.u, s.pad.d} = 2'b10;
                        if (s.pad.valid && b[7:6] == 2'b11) {s.pad.u, s.pad.d} = 2'b01;
                    end
                    5: if (s.pad.valid) {s.pad.y, s.pad.b, s.pad.a, s.pad.x} = b[7:4];
                    6: if (s.pad.valid) {s.pad.sta, s.pad.sel} = b[5:4];
                    default: ;
                endcase
            end
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expv,
                               input logic [63:0] actv);
        assert (actv === expv)
        else begin
            value_errs++;
            $display("FAIL %0t %s expected %h got %h", $time, name, expv, actv);
        end
    endtask

    task automatic check_event(input bit ok, input string what);
        assert (ok)
        else begin
            other_errs++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic drive_desc(input logic [2:0] field, input logic [7:0] value);
        desc.desc_valid = 1'b1;
        desc.field      = field;
        desc.value      = value;
        @(negedge usbclk);
        desc.desc_valid = 1'b0;
    endtask

    // writes all descriptor fields with the protocol last
    task automatic classify(input logic [7:0] cls, input logic [7:0] sub,
                            input logic [7:0] proto, input usb_hid_pkg::dev_type_e want);
        for (int f = 0; f < `USB_HID_FIELD_CLASS; f++) begin
            drive_desc(3'(f), rand_byte());  // vendor and product ids
        end
        drive_desc(3'(`USB_HID_FIELD_CLASS), cls);
        drive_desc(3'(`USB_HID_FIELD_SUBCLASS), sub);
        drive_desc(3'(`USB_HID_FIELD_PROTOCOL), proto);
        check_value("typ", 64'(cur_typ), 64'(typ));  // field stored but type not yet set
        @(negedge usbclk);
        cur_typ = want;
        check_value("typ", 64'(cur_typ), 64'(typ));
    endtask

    // sends frame_buf[0..n-1] and unplugs before byte drop_at when it is not negative
    task automatic send_frame(input int n, input int drop_at);
        usb_hid_pkg::dev_type_e dtyp;
        expect_t                e;
        int                     applied;
        int                     cyc;
        dtyp    = cur_typ;
        applied = n;
        link.frame = 1'b1;
        @(negedge usbclk);
        for (int i = 0; i < n; i++) begin
            if (i == drop_at) begin
                repeat (2) @(negedge usbclk);  // earlier bytes reach the state
                link.connected = 1'b0;
                @(negedge usbclk);
                cur_typ = usb_hid_pkg::dev_none;
                check_value("typ", 64'(cur_typ), 64'(typ));
                applied = i;
            end
            link.byte_valid = 1'b1;
            link.data       = frame_buf[i];
            @(negedge usbclk);
            link.byte_valid = 1'b0;
            if (i < `USB_HID_REPORT_BYTES) model_raw[i*8 +: 8] = frame_buf[i];
            if (rand_byte() < 8'd48) @(negedge usbclk);  // occasional idle cycle
        end
        model = ref_state(dtyp, frame_buf, applied, model);
        link.frame = 1'b0;
        if (cur_typ != usb_hid_pkg::dev_none) begin
            e.typ   = cur_typ;
            e.state = model;
            e.raw   = model_raw;
            exp_q.push_back(e);
            cyc = 0;
            while (!report && cyc < 8) begin
                @(negedge usbclk);
                cyc++;
            end
            check_event(cyc == 2, "report pulse did not come two cycles after frame end");
            if (cur_typ == usb_hid_pkg::dev_mouse) begin
                model.mouse.dx = '0;  // relative motion lasts one report
                model.mouse.dy = '0;
            end
        end
        repeat (4) @(negedge usbclk);
    endtask

    task automatic random_frame(input int n);
        for (int i = 0; i < n; i++) begin
            frame_buf[i] = rand_byte();
        end
    endtask

    // gamepad record with forced axis values and skip marks mixed in
    task automatic pad_frame();
        logic [7:0] pick;
        random_frame(8);
        pick = rand_byte();
        case (pick[1:0])
            2'd0: frame_buf[0] = 8'h00;
            2'd1: frame_buf[0] = 8'hff;
            2'd2: frame_buf[0][1:0] = `USB_HID_PAD_SKIP_MARK;
            default: ;
        endcase
        if (pick[3:2] == 2'd0) frame_buf[1] = 8'h00;
        if (pick[3:2] == 2'd1) frame_buf[1] = 8'hff;
    endtask

    // compares typ, state and raw_report at every report pulse
    initial begin
        expect_t e;
        forever begin
            @(negedge usbclk);
            if (report) begin
                reports_seen++;
                if (exp_q.size() == 0) begin
                    check_event(1'b0, "report pulse where none was expected");
                end else begin
                    e = exp_q.pop_front();
                    check_value("typ", 64'(e.typ), 64'(typ));
                    check_value("state", e.state, state);
                    check_value("raw_report", e.raw, raw_report);
                    if (e.typ == usb_hid_pkg::dev_mouse) begin
                        @(negedge usbclk);
                        check_value("state.mouse.dx", 64'd0, 64'(state.mouse.dx));
                        check_value("state.mouse.dy", 64'd0, 64'(state.mouse.dy));
                    end
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (N_FRAMES * FRAME_CYCLES + MARGIN_CYCLES));
        $display("timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int frame_len;
        lcg_state    = 32'hbd78_512f;
        usbrst_n     = 1'b0;
        link         = '0;
        desc         = '0;
        cur_typ      = usb_hid_pkg::dev_none;
        model        = '0;
        model_raw    = '0;
        value_errs   = 0;
        other_errs   = 0;
        reports_seen = 0;
        link.connected = 1'b1;
        repeat (RESET_CYCLES) @(negedge usbclk);
        usbrst_n = 1'b1;
        @(negedge usbclk);
        check_value("typ", 64'(usb_hid_pkg::dev_none), 64'(typ));
        check_value("report", 64'd0, 64'(report));
        check_value("state", 64'd0, state);
        check_value("raw_report", 64'd0, raw_report);

        // frames to a non hid interface give no report
        classify(8'h08, 8'h01, 8'h01, usb_hid_pkg::dev_none);
        repeat (2) begin
            random_frame(8);
            send_frame(8, -1);
        end

        classify(8'h03, 8'h01, 8'h01, usb_hid_pkg::dev_keyboard);
        repeat (KBD_FRAMES) begin
            random_frame(8);
            send_frame(8, -1);
        end
        random_frame(11);
        send_frame(11, -1);  // only eight bytes kept
        random_frame(8);
        send_frame(8, 3);    // unplugged mid frame
        link.connected = 1'b1;
        @(negedge usbclk);

        classify(8'h03, 8'h01, 8'h02, usb_hid_pkg::dev_mouse);
        repeat (MOUSE_FRAMES) begin
            frame_len = 3 + (rand_byte() % 6);
            random_frame(frame_len);
            send_frame(frame_len, -1);
        end

        classify(8'h03, 8'h00, 8'h00, usb_hid_pkg::dev_gamepad);
        repeat (PAD_FRAMES) begin
            pad_frame();
            send_frame(8, -1);
        end

        repeat (4) @(negedge usbclk);
        check_event(exp_q.size() == 0, "expected report pulses never arrived");
        $display("reports %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 reports_seen, value_errs, other_errs, dut_i.u_asserts.fails);
        if (value_errs == 0 && other_errs == 0 && dut_i.u_asserts.fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- usb_hid_asserts.sv
// hid report assertions
// watch the report pulse and the device type of the report top,
// attached to every usb_hid_report instance by bind
`timescale 1ns/100ps

module usb_hid_asserts (
    input logic                   usbclk,
    input logic                   usbrst_n,
    input logic                   report,
    input usb_hid_pkg::dev_type_e typ,
    input logic                   connected
);

    int unsigned fails = 0;

    // one pulse per frame
    report_single: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report |=> !report)
    else begin
        fails++;
        $error("report high two cycles in a row");
    end

    report_has_type: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report |-> typ != usb_hid_pkg::dev_none)
    else begin
        fails++;
        $error("report high with no device type");
    end

    // unplug clears the type on the next cycle
    drop_clears_type: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $fell(connected) |=> typ == usb_hid_pkg::dev_none)
    else begin
        fails++;
        $error("device type kept after disconnect");
    end

endmodule

bind usb_hid_report usb_hid_asserts u_asserts (
    .usbclk    (usbclk),
    .usbrst_n  (usbrst_n),
    .report    (report),
    .typ       (typ),
    .connected (link.connected)
);

//--- usb_hid_pkg.sv
// usb hid report types
// device type, link and descriptor inputs, captured byte events and
// the decoded keyboard, mouse and gamepad state sharing one 64-bit word
`include "usb_hid_settings.svh"

package usb_hid_pkg;

    typedef enum logic [1:0] {
        dev_none     = 2'd0,
        dev_keyboard = 2'd1,
        dev_mouse    = 2'd2,
        dev_gamepad  = 2'd3
    } dev_type_e;

    // one cycle of link layer output
    typedef struct packed {
        logic       frame;       // report frame in progress
        logic       byte_valid;  // one cycle strobe per byte
        logic [7:0] data;
        logic       connected;
        logic       desc_valid;
    } link_in_t;

    // descriptor field write
    typedef struct packed {
        logic                       desc_valid;
        logic [`USB_HID_IDX_W-1:0]  field;
        logic [7:0]                 value;
    } desc_wr_t;

    // captured report byte and its position in the frame
    typedef struct packed {
        logic                       valid;
        logic [`USB_HID_IDX_W-1:0]  idx;
        logic [7:0]                 data;
    } byte_evt_t;

    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  key4;
        logic [7:0]  key3;
        logic [7:0]  key2;
        logic [7:0]  key1;
        logic [7:0]  modifiers;
    } kbd_state_t;

    typedef struct packed {
        logic [39:0]       rsvd;
        logic signed [7:0] dy;       // cleared after report
        logic signed [7:0] dx;       // cleared after report
        logic [7:0]        buttons;  // {5'bx, middle, right, left}
    } mouse_state_t;

    typedef struct packed {
        logic [52:0] rsvd;
        logic        valid;  // current record is not a skipped one
        logic        sta;
        logic        sel;
        logic        y;
        logic        x;
        logic        b;
        logic        a;
        logic        d;
        logic        u;
        logic        r;
        logic        l;
    } pad_state_t;

    // view picked by dev_type_e
    typedef union packed {
        kbd_state_t   kbd;
        mouse_state_t mouse;
        pad_state_t   pad;
    } hid_state_u;

endpackage

//--- usb_hid_report.sv
// usb hid report top
// report capture and class detection run side by side on the link
// layer output, the decoder combines the captured bytes with the type
`timescale 1ns/100ps
`include "usb_hid_settings.svh"

module usb_hid_report (
    input  logic                                usbclk,
    input  logic                                usbrst_n,
    input  usb_hid_pkg::link_in_t               link,
    input  usb_hid_pkg::desc_wr_t               desc,
    output usb_hid_pkg::dev_type_e              typ,
    output logic                                report,     // one cycle per frame
    output usb_hid_pkg::hid_state_u             state,
    output logic [`USB_HID_REPORT_BYTES*8-1:0]  raw_report  // byte 0 in the low bits
);

    usb_hid_pkg::byte_evt_t evt;
    logic                   frame_end;

    hid_report_capture u_capture (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .link       (link),
        .evt        (evt),
        .frame_end  (frame_end),
        .raw_report (raw_report)
    );

    hid_class_detect u_class (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .desc       (desc),
        .connected  (link.connected),
        .typ        (typ)
    );

    hid_report_decode u_decode (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .typ        (typ),
        .evt        (evt),
        .frame_end  (frame_end),
        .report     (report),
        .state      (state)
    );

endmodule

//--- usb_hid_settings.svh
// usb hid report settings
// report length, descriptor field layout, interface class codes
// and the gamepad record marker shared by the report-side blocks
`ifndef USB_HID_SETTINGS_SVH
`define USB_HID_SETTINGS_SVH

// interrupt report capture
`define USB_HID_REPORT_BYTES 8
`define USB_HID_IDX_W 3

// descriptor fields, in write order
// 0/1 vendor id low/high, 2/3 product id low/high
`define USB_HID_DESC_FIELDS 7
`define USB_HID_FIELD_CLASS 4
`define USB_HID_FIELD_SUBCLASS 5
`define USB_HID_FIELD_PROTOCOL 6

// interface codes
`define USB_HID_CLASS_HID 8'd3
`define USB_HID_SUBCLASS_BOOT 8'd1
`define USB_HID_PROTO_KEYBOARD 8'd1

// byte 0 low bits of a dual-shock adapter record to be skipped
`define USB_HID_PAD_SKIP_MARK 2'b10

`endif

//--- verilog.f
+incdir+.
usb_hid_pkg.sv
hid_report_capture.sv
hid_class_detect.sv
hid_report_decode.sv
usb_hid_report.sv
usb_hid_asserts.sv
tb_usb_hid.sv
